// ==== src/noc_cfg_pkg.sv ====
package noc_cfg_pkg;

    // router geometry
    localparam int NUM_PORTS = 5;
    localparam int NUM_VCS   = 4;

    // a port never routes back to itself
    localparam int NUM_OUTS  = NUM_PORTS - 1;

    // one bit per VC of a port
    typedef logic [NUM_VCS-1:0] vc_onehot_t;

    // one bit per output port reachable from an input port
    typedef logic [NUM_OUTS-1:0] dest_onehot_t;

    // one bit per router port
    typedef logic [NUM_PORTS-1:0] port_onehot_t;

    // Position of out_port inside the dest vector of in_port.
    // Outputs below the input keep their number, outputs above it shift down
    // by one to close the gap of the excluded self port.
    // The same rule numbers the requesting inputs at a second-level arbiter,
    // called there as dest_index(out_port, in_port).
    function automatic int dest_index(input int in_port, input int out_port);
        int idx;
        if (out_port < in_port) begin
            idx = out_port;
        end else begin
            idx = out_port - 1;
        end
        return idx;
    endfunction

endpackage

// ==== src/alloc_pkg.sv ====
package alloc_pkg;

    // request of one input VC, as presented by the input port
    typedef struct packed {
        noc_cfg_pkg::vc_onehot_t   free_ovc;     // free output VCs it may take
        noc_cfg_pkg::dest_onehot_t dest;         // routed output port
        logic                      request;      // flit waiting
        logic                      ovc_assigned; // already holds an output VC
        logic                      ovc_not_full; // that output VC has room
    } ivc_req_t;

    // switch allocation result of one input port
    typedef struct packed {
        noc_cfg_pkg::vc_onehot_t   ivc;     // winning input VC
        noc_cfg_pkg::dest_onehot_t dest;    // output port it goes to
        logic                      granted;
    } sw_grant_t;

    // output VC allocation result of one input port
    typedef struct packed {
        noc_cfg_pkg::vc_onehot_t ovc; // output VC handed out
        noc_cfg_pkg::vc_onehot_t ivc; // input VC that receives it
    } vc_grant_t;

    // Per input VC, produced by the candidate stage.
    // ovc is the one free output VC picked for this input VC, or zero when
    // it only has an assigned output VC.
    // valid is the masked switch request seen by the switch allocator.
    typedef struct packed {
        noc_cfg_pkg::vc_onehot_t ovc;
        logic                    valid;
    } cand_t;

endpackage

// ==== src/rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] request,
    input  logic             update,
    output logic [WIDTH-1:0] grant
);

    logic [WIDTH-1:0]   prio;    // one-hot, position with top priority
    logic [2*WIDTH-1:0] req_dbl;
    logic [2*WIDTH-1:0] gnt_dbl;
    logic               any_req;

    // request vector twice so the search wraps past the top index
    assign req_dbl = {request, request};

    // the borrow of the subtraction stops at the first request at or above
    // prio, so masking with the inverted difference leaves only that bit
    assign gnt_dbl = req_dbl & ~(req_dbl - {{WIDTH{1'b0}}, prio});

    // only one of the halves can hold the winner
    assign grant = gnt_dbl[WIDTH-1:0] | gnt_dbl[2*WIDTH-1:WIDTH];

    assign any_req = |request;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio <= {{(WIDTH-1){1'b0}}, 1'b1}; // index 0 first
        end else if (update && any_req) begin
            // rotate: next index after the winner gets top priority
            prio <= {grant[WIDTH-2:0], grant[WIDTH-1]};
        end
    end

endmodule

// ==== src/vc_candidate_stage.sv ====
`timescale 1ns/10ps

module vc_candidate_stage (
    input  logic clk,
    input  logic arst_n,
    input  alloc_pkg::ivc_req_t [noc_cfg_pkg::NUM_PORTS-1:0][noc_cfg_pkg::NUM_VCS-1:0] ivc_req,
    output alloc_pkg::cand_t    [noc_cfg_pkg::NUM_PORTS-1:0][noc_cfg_pkg::NUM_VCS-1:0] cand
);

    localparam int NP = noc_cfg_pkg::NUM_PORTS;
    localparam int NV = noc_cfg_pkg::NUM_VCS;

    for (genvar p = 0; p < NP; p++) begin : g_port
        for (genvar v = 0; v < NV; v++) begin : g_vc
            logic                    assigned_req; // holds an output VC with room
            logic                    has_free;
            noc_cfg_pkg::vc_onehot_t pick;

            assign assigned_req = ivc_req[p][v].request
                                & ivc_req[p][v].ovc_assigned
                                & ivc_req[p][v].ovc_not_full;

            assign has_free = |ivc_req[p][v].free_ovc;

            // one output VC out of the free ones
            rr_arbiter #(
                .WIDTH (NV)
            ) u_ovc_arb (
                .clk     (clk),
                .arst_n  (arst_n),
                .request (ivc_req[p][v].free_ovc),
                .update  (has_free),
                .grant   (pick)
            );

            assign cand[p][v] = '{ovc: pick, valid: assigned_req | has_free};
        end
    end

endmodule

// ==== src/sw_alloc_stage.sv ====
`timescale 1ns/10ps

module sw_alloc_stage (
    input  logic clk,
    input  logic arst_n,
    input  alloc_pkg::cand_t    [noc_cfg_pkg::NUM_PORTS-1:0][noc_cfg_pkg::NUM_VCS-1:0] cand,
    input  alloc_pkg::ivc_req_t [noc_cfg_pkg::NUM_PORTS-1:0][noc_cfg_pkg::NUM_VCS-1:0] ivc_req,
    output alloc_pkg::sw_grant_t [noc_cfg_pkg::NUM_PORTS-1:0] sw_grant
);

    localparam int NP = noc_cfg_pkg::NUM_PORTS;
    localparam int NV = noc_cfg_pkg::NUM_VCS;
    localparam int NO = noc_cfg_pkg::NUM_OUTS;

    noc_cfg_pkg::vc_onehot_t   [NP-1:0] first_req;
    noc_cfg_pkg::vc_onehot_t   [NP-1:0] first_grant;
    noc_cfg_pkg::dest_onehot_t [NP-1:0] sel_dest;     // per input port
    noc_cfg_pkg::dest_onehot_t [NP-1:0] second_req;   // per output port
    noc_cfg_pkg::dest_onehot_t [NP-1:0] second_grant; // per output port
    noc_cfg_pkg::dest_onehot_t [NP-1:0] granted_dest; // per input port
    noc_cfg_pkg::port_onehot_t          port_granted;

    // first-level requests, and dest of each first-level winner
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            sel_dest[i] = '0;
            for (int v = 0; v < NV; v++) begin
                first_req[i][v] = cand[i][v].valid;
                if (first_grant[i][v]) begin
                    sel_dest[i] |= ivc_req[i][v].dest;
                end
            end
        end
    end

    for (genvar i = 0; i < NP; i++) begin : g_in_port
        // pointer only moves once the port actually wins the switch
        rr_arbiter #(
            .WIDTH (NV)
        ) u_first_arb (
            .clk     (clk),
            .arst_n  (arst_n),
            .request (first_req[i]),
            .update  (port_granted[i]),
            .grant   (first_grant[i])
        );

        assign port_granted[i] = |granted_dest[i];

        assign sw_grant[i] = '{
            ivc:     port_granted[i] ? first_grant[i] : '0,
            dest:    granted_dest[i],
            granted: port_granted[i]
        };
    end

    for (genvar o = 0; o < NP; o++) begin : g_out_port
        // crossbar between input dest bits and output arbiter slots
        for (genvar i = 0; i < NP; i++) begin : g_map
            if (i != o) begin : g_other
                localparam int K_OUT = noc_cfg_pkg::dest_index(o, i); // slot at output
                localparam int K_IN  = noc_cfg_pkg::dest_index(i, o); // bit at input

                assign second_req[o][K_OUT] = sel_dest[i][K_IN];
                assign granted_dest[i][K_IN] = second_grant[o][K_OUT];
            end
        end

        rr_arbiter #(
            .WIDTH (NO)
        ) u_second_arb (
            .clk     (clk),
            .arst_n  (arst_n),
            .request (second_req[o]),
            .update  (|second_req[o]), // free running, moves on every grant
            .grant   (second_grant[o])
        );
    end

endmodule

// ==== src/vc_grant_stage.sv ====
`timescale 1ns/10ps

module vc_grant_stage (
    input  alloc_pkg::cand_t     [noc_cfg_pkg::NUM_PORTS-1:0][noc_cfg_pkg::NUM_VCS-1:0] cand,
    input  alloc_pkg::sw_grant_t [noc_cfg_pkg::NUM_PORTS-1:0] sw_grant,
    output alloc_pkg::vc_grant_t [noc_cfg_pkg::NUM_PORTS-1:0] vc_grant,
    output noc_cfg_pkg::vc_onehot_t [noc_cfg_pkg::NUM_PORTS-1:0] ovc_allocated
);

    localparam int NP = noc_cfg_pkg::NUM_PORTS;
    localparam int NV = noc_cfg_pkg::NUM_VCS;

    noc_cfg_pkg::vc_onehot_t [NP-1:0] win_ovc;  // candidate of the switch winner
    noc_cfg_pkg::port_onehot_t        has_cand;

    // one-hot mux of the candidates by the switch-granted input VC
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            win_ovc[i] = '0;
            for (int v = 0; v < NV; v++) begin
                if (sw_grant[i].ivc[v]) begin
                    win_ovc[i] |= cand[i][v].ovc;
                end
            end
            has_cand[i] = |win_ovc[i]; // ivc stays zero unless the port won the switch
        end
    end

    // assigned-VC traffic wins the switch without a candidate and gets no VC grant
    for (genvar i = 0; i < NP; i++) begin : g_port
        assign vc_grant[i] = has_cand[i]
                           ? '{ovc: win_ovc[i], ivc: sw_grant[i].ivc}
                           : '0;
    end

    // Demux each winner's candidate to the output port it was granted.
    // Only one input can hold a given output, so the OR never merges two
    // grants for the same output VC.
    always_comb begin
        ovc_allocated = '0;
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                if (i != o) begin
                    if (has_cand[i] && sw_grant[i].dest[noc_cfg_pkg::dest_index(i, o)]) begin
                        ovc_allocated[o] |= win_ovc[i];
                    end
                end
            end
        end
    end

endmodule

// ==== src/comb_nonspec_allocator.sv ====
`timescale 1ns/10ps

module comb_nonspec_allocator (
    input  logic clk,
    input  logic arst_n,
    input  alloc_pkg::ivc_req_t [noc_cfg_pkg::NUM_PORTS-1:0][noc_cfg_pkg::NUM_VCS-1:0] ivc_req,
    output alloc_pkg::sw_grant_t    [noc_cfg_pkg::NUM_PORTS-1:0] sw_grant,
    output alloc_pkg::vc_grant_t    [noc_cfg_pkg::NUM_PORTS-1:0] vc_grant,
    output noc_cfg_pkg::vc_onehot_t [noc_cfg_pkg::NUM_PORTS-1:0] ovc_allocated
);

    // candidate output VC and masked switch request per input VC
    alloc_pkg::cand_t [noc_cfg_pkg::NUM_PORTS-1:0][noc_cfg_pkg::NUM_VCS-1:0] cand;

    vc_candidate_stage u_cand (
        .clk     (clk),
        .arst_n  (arst_n),
        .ivc_req (ivc_req),
        .cand    (cand)
    );

    sw_alloc_stage u_sw_alloc (
        .clk      (clk),
        .arst_n   (arst_n),
        .cand     (cand),
        .ivc_req  (ivc_req),
        .sw_grant (sw_grant)
    );

    // reads the same sw_grant the outside sees, all in one cycle
    vc_grant_stage u_vc_grant (
        .cand          (cand),
        .sw_grant      (sw_grant),
        .vc_grant      (vc_grant),
        .ovc_allocated (ovc_allocated)
    );

endmodule

// ==== bench/allocator_chk.sv ====
`timescale 1ns/10ps

module allocator_chk (
    input logic clk,
    input logic arst_n,
    input alloc_pkg::sw_grant_t [noc_cfg_pkg::NUM_PORTS-1:0] sw_grant,
    input alloc_pkg::vc_grant_t [noc_cfg_pkg::NUM_PORTS-1:0] vc_grant
);

    localparam int NP = noc_cfg_pkg::NUM_PORTS;

    int fail_count = 0; // read by the testbench summary

    noc_cfg_pkg::port_onehot_t [NP-1:0] holders; // per output, inputs granted to it

    // input i names output o at bit o below i, at o-1 above it
    always_comb begin
        holders = '0;
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                if (i != o) begin
                    holders[o][i] = sw_grant[i].dest[(o < i) ? o : o - 1];
                end
            end
        end
    end

    for (genvar i = 0; i < NP; i++) begin : g_port
        a_sw_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(sw_grant[i].ivc) && $onehot0(sw_grant[i].dest))
        else begin
            $error("port %0d switch grant ivc or dest is not one-hot", i);
            fail_count++;
        end

        a_vc_needs_sw: assert property (@(posedge clk) disable iff (!arst_n)
            (|vc_grant[i].ovc) |-> sw_grant[i].granted)
        else begin
            $error("port %0d has an output VC grant without a switch grant", i);
            fail_count++;
        end

        a_one_holder: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(holders[i]))
        else begin
            $error("output %0d granted to more than one input port", i);
            fail_count++;
        end
    end

endmodule

// ==== bench/allocator_tb.sv ====
`timescale 1ns/10ps

module allocator_tb;

    localparam int NP = noc_cfg_pkg::NUM_PORTS;
    localparam int NV = noc_cfg_pkg::NUM_VCS;
    localparam int NO = noc_cfg_pkg::NUM_OUTS;
    localparam int RESET_TIMEOUT = 50; // cycles

    typedef alloc_pkg::ivc_req_t     [NP-1:0][NV-1:0] req_array_t;
    typedef alloc_pkg::sw_grant_t    [NP-1:0]         sw_array_t;
    typedef alloc_pkg::vc_grant_t    [NP-1:0]         vc_array_t;
    typedef noc_cfg_pkg::vc_onehot_t [NP-1:0]         alloc_t;

    logic       clk;
    logic       arst_n;
    req_array_t ivc_req;
    sw_array_t  sw_grant;
    vc_array_t  vc_grant;
    alloc_t     ovc_allocated;

    int     checks;
    int     mismatches;
    int     other_errors;
    integer seed;

    comb_nonspec_allocator uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .ivc_req       (ivc_req),
        .sw_grant      (sw_grant),
        .vc_grant      (vc_grant),
        .ovc_allocated (ovc_allocated)
    );

    bind comb_nonspec_allocator allocator_chk u_chk (
        .clk      (clk),
        .arst_n   (arst_n),
        .sw_grant (sw_grant),
        .vc_grant (vc_grant)
    );

    always #5 clk = ~clk;

    initial begin
        clk     = 1'b0;
        arst_n  = 1'b0;
        ivc_req = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    end

    // bit of out_port in the dest vector of in_port with the self port skipped
    function automatic int dest_bit(input int in_port, input int out_port);
        return (out_port < in_port) ? out_port : out_port - 1;
    endfunction

    function automatic alloc_pkg::ivc_req_t assigned_req(input int in_port, input int out_port);
        alloc_pkg::ivc_req_t r;
        r = '0;
        r.dest[dest_bit(in_port, out_port)] = 1'b1;
        r.request      = 1'b1;
        r.ovc_assigned = 1'b1;
        r.ovc_not_full = 1'b1;
        return r;
    endfunction

    function automatic alloc_pkg::ivc_req_t free_req(input int in_port, input int out_port,
                                                     input int ovc);
        alloc_pkg::ivc_req_t r;
        r = '0;
        r.dest[dest_bit(in_port, out_port)] = 1'b1;
        r.free_ovc[ovc] = 1'b1;
        r.request       = 1'b1;
        return r;
    endfunction

    function automatic alloc_pkg::sw_grant_t sw_exp(input int vc, input int dbit);
        alloc_pkg::sw_grant_t g;
        g = '0;
        g.ivc[vc]    = 1'b1;
        g.dest[dbit] = 1'b1;
        g.granted    = 1'b1;
        return g;
    endfunction

    task automatic check_sw_grant(input string name, input int port,
                                  input alloc_pkg::sw_grant_t exp,
                                  input alloc_pkg::sw_grant_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: port %0d sw_grant expected %h, actual %h",
                     name, port, exp, act);
        end
    endtask

    task automatic check_vc_grant(input string name, input int port,
                                  input alloc_pkg::vc_grant_t exp,
                                  input alloc_pkg::vc_grant_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: port %0d vc_grant expected %h, actual %h",
                     name, port, exp, act);
        end
    endtask

    task automatic check_alloc(input string name, input alloc_t exp, input alloc_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: ovc_allocated expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_outputs(input string name, input sw_array_t exp_sw,
                                 input vc_array_t exp_vc, input alloc_t exp_alloc);
        for (int p = 0; p < NP; p++) begin
            check_sw_grant(name, p, exp_sw[p], sw_grant[p]);
            check_vc_grant(name, p, exp_vc[p], vc_grant[p]);
        end
        check_alloc(name, exp_alloc, ovc_allocated);
    endtask

    // outputs settle in the same cycle and are checked 1 ns after the edge
    task automatic drive(input req_array_t reqs);
        @(posedge clk);
        ivc_req <= reqs;
        #1;
    endtask

    task automatic wait_reset(output bit done);
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        done = (arst_n === 1'b1);
    endtask

    task automatic test_idle();
        for (int n = 0; n < 5; n++) begin
            drive('0);
            check_outputs($sformatf("idle_%0d", n), '0, '0, '0);
        end
    endtask

    task automatic test_assigned_ovc();
        req_array_t reqs;
        sw_array_t  exp_sw;
        reqs = '0;
        reqs[1][2] = assigned_req(1, 3);
        exp_sw = '0;
        exp_sw[1] = sw_exp(2, dest_bit(1, 3));
        drive(reqs);
        check_outputs("assigned_ovc", exp_sw, '0, '0); // no free bit so no VC grant
        reqs[1][2].ovc_not_full = 1'b0;
        drive(reqs);
        check_outputs("assigned_ovc_full", '0, '0, '0);
    endtask

    task automatic test_free_ovc();
        req_array_t reqs;
        sw_array_t  exp_sw;
        vc_array_t  exp_vc;
        alloc_t     exp_alloc;
        int         in_p;
        int         out_p;
        int         vc;
        int         ovc;
        for (int n = 0; n < 6; n++) begin
            in_p  = $unsigned($random(seed)) % NP;
            out_p = (in_p + 1 + $unsigned($random(seed)) % NO) % NP; // never itself
            vc    = $unsigned($random(seed)) % NV;
            ovc   = $unsigned($random(seed)) % NV;
            reqs = '0;
            reqs[in_p][vc] = free_req(in_p, out_p, ovc);
            exp_sw    = '0;
            exp_vc    = '0;
            exp_alloc = '0;
            exp_sw[in_p] = sw_exp(vc, dest_bit(in_p, out_p));
            exp_vc[in_p].ovc[ovc] = 1'b1;
            exp_vc[in_p].ivc[vc]  = 1'b1;
            exp_alloc[out_p][ovc] = 1'b1; // indexed by the output port itself
            drive(reqs);
            check_outputs($sformatf("free_ovc_%0d", n), exp_sw, exp_vc, exp_alloc);
        end
    endtask

    task automatic test_output_conflict();
        req_array_t reqs;
        sw_array_t  exp_sw;
        int         winner;
        reqs = '0;
        reqs[0][0] = assigned_req(0, 4);
        reqs[2][0] = assigned_req(2, 4);
        winner = 0;
        for (int n = 0; n < 6; n++) begin
            drive(reqs);
            if (n == 0) begin
                winner = sw_grant[2].granted ? 2 : 0; // start depends on history
            end else begin
                winner = (winner == 0) ? 2 : 0;
            end
            exp_sw = '0;
            exp_sw[winner] = sw_exp(0, dest_bit(winner, 4));
            check_outputs($sformatf("output_conflict_%0d", n), exp_sw, '0, '0);
        end
    endtask

    task automatic test_port_fairness();
        req_array_t reqs;
        sw_array_t  exp_sw;
        int         win_vc;
        int         win_out;
        // a lone win of vc0 leaves top priority at vc1
        reqs = '0;
        reqs[2][0] = assigned_req(2, 1);
        exp_sw = '0;
        exp_sw[2] = sw_exp(0, dest_bit(2, 1));
        drive(reqs);
        check_outputs("port_fairness_prime", exp_sw, '0, '0);
        reqs = '0;
        reqs[2][1] = assigned_req(2, 0);
        reqs[2][3] = assigned_req(2, 4);
        win_vc = 1;
        for (int n = 0; n < 6; n++) begin
            drive(reqs);
            win_out = (win_vc == 1) ? 0 : 4;
            exp_sw = '0;
            exp_sw[2] = sw_exp(win_vc, dest_bit(2, win_out));
            check_outputs($sformatf("port_fairness_%0d", n), exp_sw, '0, '0);
            win_vc = (win_vc == 1) ? 3 : 1;
        end
    endtask

    task automatic finish_run();
        int asserts;
        asserts = uut.u_chk.fail_count;
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, other_errors, asserts);
        if (mismatches + other_errors + asserts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        bit reset_done;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        seed         = 32'he7f4_d511;
        wait_reset(reset_done);
        if (!reset_done) begin
            other_errors++;
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
        end else begin
            test_idle();
            test_assigned_ovc();
            test_free_ovc();
            test_output_conflict();
            test_port_fairness();
            drive('0);
        end
        finish_run();
    end

endmodule

// ==== src.f ====
src/noc_cfg_pkg.sv
src/alloc_pkg.sv
src/rr_arbiter.sv
src/vc_candidate_stage.sv
src/sw_alloc_stage.sv
src/vc_grant_stage.sv
src/comb_nonspec_allocator.sv
bench/allocator_chk.sv
bench/allocator_tb.sv
